/* filelist.f */
logic/execute_pkg.sv
logic/unit_if.sv
logic/alu.sv
logic/branch_address_unit.sv
logic/divider.sv
logic/execute_stage.sv
logic/execute_top.sv
tests/execute_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module execute_tb -Mdir obj_dir &&
./obj_dir/Vexecute_tb | tee /dev/stderr | grep -qx "Simulation finished: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* tests/execute_tb.sv */
`timescale 1ns/1ns

module execute_tb;
  import execute_pkg::*;

  localparam int div_steps = xlen;
  localparam int wait_limit = 200;

  logic clock;
  logic reset;
  logic flush;
  logic hold;
  logic valid0;
  logic [kind_w-1:0] kind0;
  logic [func_w-1:0] func0;
  logic use_imm0;
  logic [xlen-1:0] rs1_data0;
  logic [xlen-1:0] rs2_data0;
  logic [xlen-1:0] imm0;
  logic [xlen-1:0] pc0;
  logic valid1;
  logic [func_w-1:0] func1;
  logic use_imm1;
  logic [xlen-1:0] rs1_data1;
  logic [xlen-1:0] rs2_data1;
  logic [xlen-1:0] imm1;
  logic res_valid0;
  logic [xlen-1:0] res_data0;
  logic [xlen-1:0] mem_address;
  logic [xlen-1:0] store_data;
  logic load;
  logic store;
  logic exception;
  logic [cause_w-1:0] cause;
  logic redirect;
  logic [xlen-1:0] redirect_pc;
  logic res_valid1;
  logic [xlen-1:0] res_data1;
  logic stall;

  // Reference model state and next values
  int m_left;
  logic m_clear;
  logic m_ready;
  logic m_stall;
  logic m_start;
  logic m_issue;
  logic m_taken;
  logic m_raw_fault;
  logic m_fault;
  logic m_jump;
  logic [cause_w-1:0] m_cause;
  logic [xlen-1:0] m_addr;
  logic [xlen-1:0] m_target;
  logic [xlen-1:0] m_wb0;
  logic [xlen-1:0] m_wb1;
  logic exp_valid0;
  logic exp_valid1;
  logic exp_load;
  logic exp_store;
  logic exp_exception;
  logic exp_redirect;
  logic [xlen-1:0] exp_data0;
  logic [xlen-1:0] exp_data1;
  logic [xlen-1:0] exp_address;
  logic [xlen-1:0] exp_store_data;
  logic [xlen-1:0] exp_target;
  logic [cause_w-1:0] exp_cause;

  int errors;
  int errors_at_start;
  int tests_run;
  int tests_failed;

  execute_top #(.div_steps(div_steps)) dut0 (.*);

  initial begin
    clock = 1'b0;
    forever begin
      #4 clock = ~clock;
    end
  end

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  function automatic logic [xlen-1:0] alu_model(input logic [func_w-1:0] fn,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    case (fn)
      fn_add: return a + b;
      fn_sub: return a - b;
      fn_and: return a & b;
      fn_or: return a | b;
      fn_xor: return a ^ b;
      fn_sll: return a << b[4:0];
      fn_srl: return a >> b[4:0];
      fn_sra: return xlen'($signed(a) >>> b[4:0]);
      fn_slt: return {31'd0, $signed(a) < $signed(b)};
      fn_sltu: return {31'd0, a < b};
      default: return '0;
    endcase
  endfunction

  function automatic logic branch_model(input logic [func_w-1:0] fn,
                                        input logic [xlen-1:0] a,
                                        input logic [xlen-1:0] b);
    case (fn)
      fn_beq: return a == b;
      fn_bne: return a != b;
      fn_blt: return $signed(a) < $signed(b);
      fn_bge: return $signed(a) >= $signed(b);
      fn_bltu: return a < b;
      fn_bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] div_model(input logic [func_w-1:0] fn,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    logic overflow;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (fn)
      fn_div: begin
        if (b == '0) return '1;
        if (overflow) return a;
        return xlen'($signed(a) / $signed(b));
      end
      fn_divu: return (b == '0) ? '1 : a / b;
      fn_rem: begin
        if (b == '0) return a;
        if (overflow) return '0;
        return xlen'($signed(a) % $signed(b));
      end
      default: return (b == '0) ? a : a % b;
    endcase
  endfunction

  always_comb begin
    m_clear = flush || exp_redirect;
    m_ready = (m_left == 1);
    m_stall = valid0 && (kind0 == kind_div) && !m_ready && !m_clear;
    m_start = valid0 && (kind0 == kind_div) && !hold && !m_clear && (m_left == 0);
    m_issue = !m_clear && !m_stall;
    m_addr = rs1_data0 + imm0;
    m_taken = (kind0 == kind_jal) || (kind0 == kind_jalr) ||
              ((kind0 == kind_branch) && branch_model(func0, rs1_data0, rs2_data0));
    m_target = (kind0 == kind_jalr) ? (m_addr & ~32'd1) : pc0 + imm0;
    m_raw_fault = 1'b0;
    m_cause = cause_fetch_misaligned;
    if (m_taken && m_target[1]) begin
      m_raw_fault = 1'b1;
    end else if ((kind0 == kind_load) || (kind0 == kind_store)) begin
      if (((func0 == fn_half) && m_addr[0]) || ((func0 == fn_word) && (m_addr[1:0] != 2'b00))) begin
        m_raw_fault = 1'b1;
        m_cause = (kind0 == kind_load) ? cause_load_misaligned : cause_store_misaligned;
      end
    end
    m_fault = valid0 && m_raw_fault;
    m_jump = valid0 && m_taken && !m_raw_fault;
    case (kind0)
      kind_jal, kind_jalr: m_wb0 = pc0 + 32'd4;
      kind_lui: m_wb0 = imm0;
      kind_div: m_wb0 = div_model(func0, rs1_data0, rs2_data0);
      default: m_wb0 = alu_model(func0, rs1_data0, use_imm0 ? imm0 : rs2_data0);
    endcase
    m_wb1 = alu_model(func1, rs1_data1, use_imm1 ? imm1 : rs2_data1);
  end

  always @(posedge clock) begin
    if (!reset) begin
      m_left <= 0;
      exp_valid0 <= 1'b0;
      exp_valid1 <= 1'b0;
      exp_load <= 1'b0;
      exp_store <= 1'b0;
      exp_exception <= 1'b0;
      exp_redirect <= 1'b0;
    end else begin
      // Divider counts down to its ready cycle
      if (m_clear) begin
        m_left <= 0;
      end else if (m_start) begin
        m_left <= div_steps + 1;
      end else if (m_left != 0) begin
        m_left <= m_left - 1;
      end
      if (!hold) begin
        exp_valid0 <= m_issue && valid0 && !m_fault && (kind0 != kind_branch) &&
                      (kind0 != kind_store);
        exp_load <= m_issue && valid0 && !m_fault && (kind0 == kind_load);
        exp_store <= m_issue && valid0 && !m_fault && (kind0 == kind_store);
        exp_exception <= m_issue && m_fault;
        exp_redirect <= m_issue && m_jump;
        exp_valid1 <= m_issue && valid1 && !m_jump && !m_fault;
        exp_data0 <= m_wb0;
        exp_data1 <= m_wb1;
        exp_address <= m_addr;
        exp_store_data <= rs2_data0;
        exp_cause <= m_cause;
        exp_target <= m_target;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic mismatch(input string name, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] want);
    $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
    errors++;
  endtask

  check_valid0: assert property (@(posedge clock) disable iff (!reset) res_valid0 == exp_valid0)
    else mismatch("res_valid0", $sampled(res_valid0), $sampled(exp_valid0));
  check_data0: assert property (@(posedge clock) disable iff (!reset)
    exp_valid0 |-> res_data0 == exp_data0)
    else mismatch("res_data0", $sampled(res_data0), $sampled(exp_data0));
  check_valid1: assert property (@(posedge clock) disable iff (!reset) res_valid1 == exp_valid1)
    else mismatch("res_valid1", $sampled(res_valid1), $sampled(exp_valid1));
  check_data1: assert property (@(posedge clock) disable iff (!reset)
    exp_valid1 |-> res_data1 == exp_data1)
    else mismatch("res_data1", $sampled(res_data1), $sampled(exp_data1));
  check_load: assert property (@(posedge clock) disable iff (!reset) load == exp_load)
    else mismatch("load", $sampled(load), $sampled(exp_load));
  check_store: assert property (@(posedge clock) disable iff (!reset) store == exp_store)
    else mismatch("store", $sampled(store), $sampled(exp_store));
  check_address: assert property (@(posedge clock) disable iff (!reset)
    (exp_load || exp_store) |-> mem_address == exp_address)
    else mismatch("mem_address", $sampled(mem_address), $sampled(exp_address));
  check_store_data: assert property (@(posedge clock) disable iff (!reset)
    exp_store |-> store_data == exp_store_data)
    else mismatch("store_data", $sampled(store_data), $sampled(exp_store_data));
  check_exception: assert property (@(posedge clock) disable iff (!reset)
    exception == exp_exception)
    else mismatch("exception", $sampled(exception), $sampled(exp_exception));
  check_cause: assert property (@(posedge clock) disable iff (!reset)
    exp_exception |-> cause == exp_cause)
    else mismatch("cause", $sampled(cause), $sampled(exp_cause));
  check_redirect: assert property (@(posedge clock) disable iff (!reset)
    redirect == exp_redirect)
    else mismatch("redirect", $sampled(redirect), $sampled(exp_redirect));
  check_target: assert property (@(posedge clock) disable iff (!reset)
    exp_redirect |-> redirect_pc == exp_target)
    else mismatch("redirect_pc", $sampled(redirect_pc), $sampled(exp_target));
  check_stall: assert property (@(posedge clock) disable iff (!reset) stall == m_stall)
    else mismatch("stall", $sampled(stall), $sampled(m_stall));

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [xlen-1:0] rand_word();
    case ($urandom % 6)
      0: return 32'h8000_0000;
      1: return 32'hffff_ffff;
      2: return xlen'($urandom % 16);
      default: return $urandom;
    endcase
  endfunction

  function automatic logic [func_w-1:0] pick_func(input logic [kind_w-1:0] kind);
    case (kind)
      kind_branch: begin
        case ($urandom % 6)
          0: return fn_beq;
          1: return fn_bne;
          2: return fn_blt;
          3: return fn_bge;
          4: return fn_bltu;
          default: return fn_bgeu;
        endcase
      end
      kind_load, kind_store: return func_w'($urandom % 3);
      kind_div: return func_w'($urandom % 4);
      default: return func_w'($urandom % 10);
    endcase
  endfunction

  task automatic fill_operands();
    use_imm0 = 1'($urandom % 2);
    rs1_data0 = rand_word();
    rs2_data0 = rand_word();
    imm0 = rand_word();
    pc0 = $urandom & ~32'd3;
    valid1 = ($urandom % 4) != 0;
    func1 = pick_func(kind_alu);
    use_imm1 = 1'($urandom % 2);
    rs1_data1 = rand_word();
    rs2_data1 = rand_word();
    imm1 = rand_word();
  endtask

  // Inputs stay put until the stage takes them
  task automatic present();
    int n;
    n = 0;
    #1;
    while ((stall || hold) && n < wait_limit) begin
      @(negedge clock);
      flush = 1'b0;
      hold = 1'b0;
      #1;
      n++;
    end
    if (stall) begin
      $display("Timeout while waiting for the stall to drop at %0t", $time);
      errors++;
    end
    @(negedge clock);
    flush = 1'b0;
    hold = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != errors_at_start) tests_failed++;
    $display("Test %s done with %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    void'($urandom(32'hae116050));
    errors = 0;
    errors_at_start = 0;
    tests_run = 0;
    tests_failed = 0;
    reset = 1'b0;
    flush = 1'b0;
    hold = 1'b0;
    valid0 = 1'b0;
    kind0 = kind_alu;
    func0 = fn_add;
    fill_operands();
    valid1 = 1'b0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset_outputs: assert (!(res_valid0 || res_valid1 || redirect || exception || load ||
                             store || stall))
      else begin
        $display("A control output is high at the end of reset, time %0t", $time);
        errors++;
      end
    reset = 1'b1;
    @(negedge clock);
    finish_test("reset");

    repeat (300) begin
      fill_operands();
      valid0 = ($urandom % 4) != 0;
      kind0 = (($urandom % 8) == 0) ? kind_lui : kind_alu;
      func0 = pick_func(kind0);
      present();
    end
    finish_test("dual_alu");

    repeat (300) begin
      fill_operands();
      valid0 = ($urandom % 6) != 0;
      case ($urandom % 3)
        0: kind0 = kind_branch;
        1: kind0 = kind_jal;
        default: kind0 = kind_jalr;
      endcase
      func0 = pick_func(kind0);
      if (($urandom % 3) == 0) rs2_data0 = rs1_data0;
      if (($urandom % 4) != 0) rs1_data0 = rs1_data0 & ~32'd3;
      imm0 = imm0 & ~32'd3;
      if (($urandom % 5) == 0) imm0 = imm0 | 32'd2;
      present();
    end
    finish_test("branch_jump");

    repeat (300) begin
      fill_operands();
      valid0 = ($urandom % 6) != 0;
      case ($urandom % 5)
        0: kind0 = kind_jal;
        1, 2: kind0 = kind_load;
        default: kind0 = kind_store;
      endcase
      func0 = pick_func(kind0);
      if (kind0 == kind_jal) imm0 = imm0 & ~32'd1;
      present();
    end
    finish_test("load_store");

    for (int i = 0; i < 48; i++) begin
      fill_operands();
      valid0 = 1'b1;
      kind0 = kind_div;
      func0 = func_w'(i % 4);
      if (i < 4) begin
        rs2_data0 = '0;
      end else if (i < 8) begin
        rs1_data0 = 32'h8000_0000;
        rs2_data0 = 32'hffff_ffff;
      end
      present();
    end
    finish_test("division");

    repeat (300) begin
      fill_operands();
      valid0 = ($urandom % 5) != 0;
      kind0 = kind_w'($urandom % 8);
      func0 = pick_func(kind0);
      flush = ($urandom % 8) == 0;
      hold = ($urandom % 6) == 0;
      present();
    end
    // Flush a division part way through, then run a fresh one
    repeat (3) begin
      fill_operands();
      valid0 = 1'b1;
      kind0 = kind_div;
      func0 = pick_func(kind_div);
      repeat (6) @(negedge clock);
      flush = 1'b1;
      @(negedge clock);
      flush = 1'b0;
      fill_operands();
      func0 = pick_func(kind_div);
      present();
    end
    // Longer freeze with a result sitting in the outputs
    fill_operands();
    valid0 = 1'b1;
    kind0 = kind_alu;
    func0 = pick_func(kind_alu);
    @(negedge clock);
    // Next instruction waits upstream while the outputs stay frozen
    fill_operands();
    func0 = pick_func(kind_alu);
    hold = 1'b1;
    repeat (4) @(negedge clock);
    hold = 1'b0;
    @(negedge clock);
    valid0 = 1'b0;
    valid1 = 1'b0;
    repeat (4) @(negedge clock);
    finish_test("flush_hold");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* logic/execute_top.sv */
`timescale 1ns/1ns

module execute_top #(
  parameter int div_steps = execute_pkg::xlen
) (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic hold,
  input  logic valid0,
  input  logic [execute_pkg::kind_w-1:0] kind0,
  input  logic [execute_pkg::func_w-1:0] func0,
  input  logic use_imm0,
  input  logic [execute_pkg::xlen-1:0] rs1_data0,
  input  logic [execute_pkg::xlen-1:0] rs2_data0,
  input  logic [execute_pkg::xlen-1:0] imm0,
  input  logic [execute_pkg::xlen-1:0] pc0,
  input  logic valid1,
  input  logic [execute_pkg::func_w-1:0] func1,
  input  logic use_imm1,
  input  logic [execute_pkg::xlen-1:0] rs1_data1,
  input  logic [execute_pkg::xlen-1:0] rs2_data1,
  input  logic [execute_pkg::xlen-1:0] imm1,
  output logic res_valid0,
  output logic [execute_pkg::xlen-1:0] res_data0,
  output logic [execute_pkg::xlen-1:0] mem_address,
  output logic [execute_pkg::xlen-1:0] store_data,
  output logic load,
  output logic store,
  output logic exception,
  output logic [execute_pkg::cause_w-1:0] cause,
  output logic redirect,
  output logic [execute_pkg::xlen-1:0] redirect_pc,
  output logic res_valid1,
  output logic [execute_pkg::xlen-1:0] res_data1,
  output logic stall
);
  import execute_pkg::*;

  logic [kind_w-1:0] bau_kind;
  logic [func_w-1:0] bau_func;
  logic [xlen-1:0] bau_rs1_data;
  logic [xlen-1:0] bau_rs2_data;
  logic [xlen-1:0] bau_imm;
  logic [xlen-1:0] bau_pc;
  logic bau_taken;
  logic [xlen-1:0] bau_target;
  logic [xlen-1:0] bau_address;
  logic [xlen-1:0] bau_link;
  logic bau_misaligned;
  logic [cause_w-1:0] bau_cause;
  logic div_busy;
  logic div_ready;
  logic div_abort;

  unit_if #(.width(xlen)) alu0_bus ();
  unit_if #(.width(xlen)) alu1_bus ();
  unit_if #(.width(xlen)) div_bus ();

  execute_stage stage0 (
    .alu0(alu0_bus),
    .alu1(alu1_bus),
    .div(div_bus),
    .*
  );

  alu alu0 (.u(alu0_bus));

  alu alu1 (.u(alu1_bus));

  branch_address_unit bau0 (
    .kind(bau_kind),
    .func(bau_func),
    .rs1_data(bau_rs1_data),
    .rs2_data(bau_rs2_data),
    .imm(bau_imm),
    .pc(bau_pc),
    .taken(bau_taken),
    .target(bau_target),
    .address(bau_address),
    .link(bau_link),
    .misaligned(bau_misaligned),
    .cause(bau_cause)
  );

  divider #(.div_steps(div_steps)) div0 (
    .clock(clock),
    .reset(reset),
    .u(div_bus),
    .abort(div_abort),
    .busy(div_busy),
    .ready(div_ready)
  );

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic hold,
  input  logic valid0,
  input  logic [execute_pkg::kind_w-1:0] kind0,
  input  logic [execute_pkg::func_w-1:0] func0,
  input  logic use_imm0,
  input  logic [execute_pkg::xlen-1:0] rs1_data0,
  input  logic [execute_pkg::xlen-1:0] rs2_data0,
  input  logic [execute_pkg::xlen-1:0] imm0,
  input  logic [execute_pkg::xlen-1:0] pc0,
  input  logic valid1,
  input  logic [execute_pkg::func_w-1:0] func1,
  input  logic use_imm1,
  input  logic [execute_pkg::xlen-1:0] rs1_data1,
  input  logic [execute_pkg::xlen-1:0] rs2_data1,
  input  logic [execute_pkg::xlen-1:0] imm1,
  unit_if.stage alu0,
  unit_if.stage alu1,
  unit_if.stage div,
  input  logic div_busy,
  input  logic div_ready,
  output logic div_abort,
  output logic [execute_pkg::kind_w-1:0] bau_kind,
  output logic [execute_pkg::func_w-1:0] bau_func,
  output logic [execute_pkg::xlen-1:0] bau_rs1_data,
  output logic [execute_pkg::xlen-1:0] bau_rs2_data,
  output logic [execute_pkg::xlen-1:0] bau_imm,
  output logic [execute_pkg::xlen-1:0] bau_pc,
  input  logic bau_taken,
  input  logic [execute_pkg::xlen-1:0] bau_target,
  input  logic [execute_pkg::xlen-1:0] bau_address,
  input  logic [execute_pkg::xlen-1:0] bau_link,
  input  logic bau_misaligned,
  input  logic [execute_pkg::cause_w-1:0] bau_cause,
  output logic res_valid0,
  output logic [execute_pkg::xlen-1:0] res_data0,
  output logic [execute_pkg::xlen-1:0] mem_address,
  output logic [execute_pkg::xlen-1:0] store_data,
  output logic load,
  output logic store,
  output logic exception,
  output logic [execute_pkg::cause_w-1:0] cause,
  output logic redirect,
  output logic [execute_pkg::xlen-1:0] redirect_pc,
  output logic res_valid1,
  output logic [execute_pkg::xlen-1:0] res_data1,
  output logic stall
);
  import execute_pkg::*;

  logic clear;
  logic is_div;
  logic issue;
  logic fault;
  logic jump;
  logic writes0;
  logic [xlen-1:0] wb_data0;

  // A redirect kills whatever follows it by one cycle
  assign clear = flush || redirect;
  assign is_div = valid0 && (kind0 == kind_div);
  assign stall = is_div && !div_ready && !clear;
  assign issue = !clear && !stall;
  assign div_abort = clear;

  assign alu0.operand_a = rs1_data0;
  assign alu0.operand_b = use_imm0 ? imm0 : rs2_data0;
  assign alu0.func = func0;
  assign alu0.start = 1'b0;
  assign alu1.operand_a = rs1_data1;
  assign alu1.operand_b = use_imm1 ? imm1 : rs2_data1;
  assign alu1.func = func1;
  assign alu1.start = 1'b0;
  assign div.operand_a = rs1_data0;
  assign div.operand_b = rs2_data0;
  assign div.func = func0;
  assign div.start = is_div && !hold && !clear && !div_busy;

  assign bau_kind = kind0;
  assign bau_func = func0;
  assign bau_rs1_data = rs1_data0;
  assign bau_rs2_data = rs2_data0;
  assign bau_imm = imm0;
  assign bau_pc = pc0;

  // Fault drops the jump, the write and the memory access
  assign fault = valid0 && bau_misaligned;
  assign jump = valid0 && bau_taken && !bau_misaligned;
  assign writes0 = valid0 && !fault && (kind0 != kind_branch) && (kind0 != kind_store);

  always_comb begin
    case (kind0)
      kind_jal, kind_jalr: wb_data0 = bau_link;
      kind_lui: wb_data0 = imm0;
      kind_div: wb_data0 = div.result;
      default: wb_data0 = alu0.result;
    endcase
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      res_valid0 <= 1'b0;
      res_valid1 <= 1'b0;
      load <= 1'b0;
      store <= 1'b0;
      exception <= 1'b0;
      redirect <= 1'b0;
    end else if (!hold) begin
      res_valid0 <= issue && writes0;
      load <= issue && valid0 && !fault && (kind0 == kind_load);
      store <= issue && valid0 && !fault && (kind0 == kind_store);
      exception <= issue && fault;
      redirect <= issue && jump;
      // Nothing in slot 1 retires behind a redirect or fault
      res_valid1 <= issue && valid1 && !jump && !fault;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      res_data0 <= wb_data0;
      mem_address <= bau_address;
      store_data <= rs2_data0;
      cause <= bau_cause;
      redirect_pc <= bau_target;
      res_data1 <= alu1.result;
    end
  end

  // A misaligned target must have become an exception instead
  redirect_target_aligned: assert property (@(posedge clock) disable iff (!reset)
    redirect |-> !redirect_pc[1]);

  // Upstream keeps the divide in slot 0 until the divider is done
  div_busy_with_divide: assert property (@(posedge clock) disable iff (!reset)
    (div_busy && !clear) |-> is_div);

endmodule

/* logic/divider.sv */
`timescale 1ns/1ns

module divider #(
  parameter int div_steps = execute_pkg::xlen
) (
  input  logic clock,
  input  logic reset,
  unit_if.unit u,
  input  logic abort,
  output logic busy,
  output logic ready
);
  import execute_pkg::*;

  localparam int w = div_steps;
  localparam int count_w = $clog2(div_steps + 1);
  localparam logic [count_w-1:0] last_step = count_w'(div_steps - 1);

  logic running;
  logic [count_w-1:0] count;
  logic load;
  logic signed_op;
  logic sign_a;
  logic sign_b;
  logic [w-1:0] dividend;
  logic [w-1:0] divisor;
  logic [w-1:0] quo_q;
  logic [w-1:0] rem_q;
  logic [w-1:0] divisor_q;
  logic neg_q;
  logic neg_r;
  logic rem_op_q;
  logic signed_q;
  logic [w:0] shifted;
  logic [w:0] trial;
  logic [w-1:0] value;

  assign busy = running || ready;
  assign load = u.start && !busy && !abort;

  assign dividend = u.operand_a[w-1:0];
  assign divisor = u.operand_b[w-1:0];
  assign signed_op = (u.func == fn_div) || (u.func == fn_rem);
  assign sign_a = signed_op && dividend[w-1];
  assign sign_b = signed_op && divisor[w-1];

  always_ff @(posedge clock) begin
    if (!reset) begin
      running <= 1'b0;
      ready <= 1'b0;
      count <= '0;
    end else if (abort) begin
      running <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (load) begin
        running <= 1'b1;
        count <= '0;
      end else if (running) begin
        count <= count + 1'b1;
        if (count == last_step) begin
          running <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Restoring step on magnitudes
  //////////////////////////////

  assign shifted = {rem_q, quo_q[w-1]};
  assign trial = shifted - {1'b0, divisor_q};

  always_ff @(posedge clock) begin
    if (load) begin
      quo_q <= sign_a ? -dividend : dividend;
      divisor_q <= sign_b ? -divisor : divisor;
      rem_q <= '0;
      // Divide by zero keeps the all ones quotient
      neg_q <= (sign_a ^ sign_b) && (divisor != '0);
      neg_r <= sign_a;
      rem_op_q <= (u.func == fn_rem) || (u.func == fn_remu);
      signed_q <= signed_op;
    end else if (running) begin
      if (trial[w]) begin
        rem_q <= shifted[w-1:0];
        quo_q <= {quo_q[w-2:0], 1'b0};
      end else begin
        rem_q <= trial[w-1:0];
        quo_q <= {quo_q[w-2:0], 1'b1};
      end
    end
  end

  always_comb begin
    if (rem_op_q) begin
      value = neg_r ? -rem_q : rem_q;
    end else begin
      value = neg_q ? -quo_q : quo_q;
    end
    u.result = signed_q ? xlen'($signed(value)) : xlen'(value);
  end

  ready_after_start: assert property (@(posedge clock) disable iff (!reset)
    $rose(ready) |-> $past(u.start && !busy && !abort, div_steps + 1));

endmodule

/* logic/branch_address_unit.sv */
`timescale 1ns/1ns

module branch_address_unit (
  input  logic [execute_pkg::kind_w-1:0] kind,
  input  logic [execute_pkg::func_w-1:0] func,
  input  logic [execute_pkg::xlen-1:0] rs1_data,
  input  logic [execute_pkg::xlen-1:0] rs2_data,
  input  logic [execute_pkg::xlen-1:0] imm,
  input  logic [execute_pkg::xlen-1:0] pc,
  output logic taken,
  output logic [execute_pkg::xlen-1:0] target,
  output logic [execute_pkg::xlen-1:0] address,
  output logic [execute_pkg::xlen-1:0] link,
  output logic misaligned,
  output logic [execute_pkg::cause_w-1:0] cause
);
  import execute_pkg::*;

  logic equal;
  logic less;
  logic less_u;
  logic cond;
  logic [xlen-1:0] pc_target;

  assign equal = rs1_data == rs2_data;
  assign less = $signed(rs1_data) < $signed(rs2_data);
  assign less_u = rs1_data < rs2_data;

  always_comb begin
    case (func)
      fn_beq: cond = equal;
      fn_bne: cond = !equal;
      fn_blt: cond = less;
      fn_bge: cond = !less;
      fn_bltu: cond = less_u;
      fn_bgeu: cond = !less_u;
      default: cond = 1'b0;
    endcase
  end

  assign address = rs1_data + imm;
  assign link = pc + xlen'(4);
  assign pc_target = pc + imm;
  // jalr drops bit 0 of the sum
  assign target = (kind == kind_jalr) ? {address[xlen-1:1], 1'b0} : pc_target;
  assign taken = (kind == kind_jal) || (kind == kind_jalr) || ((kind == kind_branch) && cond);

  always_comb begin
    misaligned = 1'b0;
    cause = cause_fetch_misaligned;
    if (taken && target[1]) begin
      misaligned = 1'b1;
    end else if ((kind == kind_load) || (kind == kind_store)) begin
      if (((func == fn_half) && address[0]) || ((func == fn_word) && (address[1:0] != 2'b00))) begin
        misaligned = 1'b1;
        cause = (kind == kind_load) ? cause_load_misaligned : cause_store_misaligned;
      end
    end
  end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ns

module alu (
  unit_if.unit u
);
  import execute_pkg::*;

  logic [4:0] shamt;
  logic less;
  logic less_u;

  assign shamt = u.operand_b[4:0];
  assign less = $signed(u.operand_a) < $signed(u.operand_b);
  assign less_u = u.operand_a < u.operand_b;

  always_comb begin
    case (u.func)
      fn_add: u.result = u.operand_a + u.operand_b;
      fn_sub: u.result = u.operand_a - u.operand_b;
      fn_and: u.result = u.operand_a & u.operand_b;
      fn_or: u.result = u.operand_a | u.operand_b;
      fn_xor: u.result = u.operand_a ^ u.operand_b;
      fn_sll: u.result = u.operand_a << shamt;
      fn_srl: u.result = u.operand_a >> shamt;
      fn_sra: u.result = $signed(u.operand_a) >>> shamt;
      // Compares give 0 or 1
      fn_slt: u.result = xlen'(less);
      fn_sltu: u.result = xlen'(less_u);
      default: u.result = '0;
    endcase
  end

endmodule

/* logic/unit_if.sv */
`timescale 1ns/1ns

interface unit_if #(
  parameter int width = execute_pkg::xlen
);
  import execute_pkg::*;

  logic [width-1:0] operand_a;
  logic [width-1:0] operand_b;
  logic [func_w-1:0] func;
  // Only the divider looks at start
  logic start;
  logic [width-1:0] result;

  modport stage (output operand_a, operand_b, func, start, input result);

  modport unit (input operand_a, operand_b, func, start, output result);

endinterface

/* logic/execute_pkg.sv */
package execute_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int xlen = 32;
  localparam int kind_w = 3;
  localparam int func_w = 4;
  localparam int cause_w = 4;

  //////////////////////////////
  // Unit kinds, slot 0
  //////////////////////////////

  localparam logic [kind_w-1:0] kind_alu = 3'd0;
  localparam logic [kind_w-1:0] kind_lui = 3'd1;
  localparam logic [kind_w-1:0] kind_branch = 3'd2;
  localparam logic [kind_w-1:0] kind_jal = 3'd3;
  localparam logic [kind_w-1:0] kind_jalr = 3'd4;
  localparam logic [kind_w-1:0] kind_load = 3'd5;
  localparam logic [kind_w-1:0] kind_store = 3'd6;
  localparam logic [kind_w-1:0] kind_div = 3'd7;

  //////////////////////////////
  // Function codes
  //////////////////////////////

  localparam logic [func_w-1:0] fn_add = 4'd0;
  localparam logic [func_w-1:0] fn_sub = 4'd1;
  localparam logic [func_w-1:0] fn_and = 4'd2;
  localparam logic [func_w-1:0] fn_or = 4'd3;
  localparam logic [func_w-1:0] fn_xor = 4'd4;
  localparam logic [func_w-1:0] fn_sll = 4'd5;
  localparam logic [func_w-1:0] fn_srl = 4'd6;
  localparam logic [func_w-1:0] fn_sra = 4'd7;
  localparam logic [func_w-1:0] fn_slt = 4'd8;
  localparam logic [func_w-1:0] fn_sltu = 4'd9;

  // Branch conditions follow funct3
  localparam logic [func_w-1:0] fn_beq = 4'd0;
  localparam logic [func_w-1:0] fn_bne = 4'd1;
  localparam logic [func_w-1:0] fn_blt = 4'd4;
  localparam logic [func_w-1:0] fn_bge = 4'd5;
  localparam logic [func_w-1:0] fn_bltu = 4'd6;
  localparam logic [func_w-1:0] fn_bgeu = 4'd7;

  // Access width for loads and stores
  localparam logic [func_w-1:0] fn_byte = 4'd0;
  localparam logic [func_w-1:0] fn_half = 4'd1;
  localparam logic [func_w-1:0] fn_word = 4'd2;

  localparam logic [func_w-1:0] fn_div = 4'd0;
  localparam logic [func_w-1:0] fn_divu = 4'd1;
  localparam logic [func_w-1:0] fn_rem = 4'd2;
  localparam logic [func_w-1:0] fn_remu = 4'd3;

  // Exception causes, as in mcause
  localparam logic [cause_w-1:0] cause_fetch_misaligned = 4'd0;
  localparam logic [cause_w-1:0] cause_load_misaligned = 4'd4;
  localparam logic [cause_w-1:0] cause_store_misaligned = 4'd6;

endpackage
